// File: verilog/leaf_settings.svh
`ifndef LEAF_SETTINGS_SVH
`define LEAF_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Network word layout.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define PACKET_BITS   49
`define PAYLOAD_BITS  32
`define LEAF_BITS     5
`define PORT_BITS     4
`define TAG_BITS      7

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Leaf geometry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define NUM_IN_PORTS  7
`define FIFO_DEPTH    8      // Entries per queue.

`endif

// File: verilog/leaf_pkg.sv
`include "leaf_settings.svh"
`default_nettype none

package leaf_pkg;

    typedef logic [`PAYLOAD_BITS-1:0] payload_t;
    typedef logic [`LEAF_BITS-1:0]    leaf_t;
    typedef logic [`PORT_BITS-1:0]    port_t;
    typedef logic [`TAG_BITS-1:0]     tag_t;

    // One network word, valid bit on top.
    typedef struct packed {
        logic     valid;
        leaf_t    leaf;
        port_t    port;
        tag_t     tag;
        payload_t payload;
    } packet_t;

endpackage

`default_nettype wire

// File: verilog/packet_fifo.sv
`include "leaf_settings.svh"
`default_nettype none

module packet_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = `FIFO_DEPTH
) (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic push,
    input  T          wdata,
    input  wire logic pop,
    output T          rdata,
    output logic      empty,
    output logic      full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T                mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            wr_en;
    logic            rd_en;

    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));
    assign wr_en = push && !full; // Dropped when full.
    assign rd_en = pop && !empty;
    assign rdata = mem[rd_ptr];   // First word falls through.

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/leaf_unpacker.sv
`include "leaf_settings.svh"
`default_nettype none

module leaf_unpacker #(
    parameter leaf_pkg::leaf_t LEAF_ID = 5'd3
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  leaf_pkg::packet_t             din,
    output logic [`NUM_IN_PORTS-1:0]      push,
    output leaf_pkg::payload_t            payload
);

    import leaf_pkg::*;

    logic     pkt_vld_q;
    leaf_t    leaf_q;
    port_t    port_q;
    payload_t payload_q;
    logic     leaf_hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_vld_q <= 1'b0;
        end else begin
            pkt_vld_q <= din.valid;
        end
    end

    always_ff @(posedge clk) begin
        leaf_q    <= din.leaf;
        port_q    <= din.port;
        payload_q <= din.payload;
    end

    assign leaf_hit = pkt_vld_q && (leaf_q == LEAF_ID);

    // Port n lands in queue n-1, port 0 and 8..15 match nothing.
    always_comb begin
        for (int i = 0; i < `NUM_IN_PORTS; i++) begin
            push[i] = leaf_hit && (port_q == port_t'(i + 1));
        end
    end

    assign payload = payload_q;

endmodule

`default_nettype wire

// File: verilog/leaf_packer.sv
`include "leaf_settings.svh"
`default_nettype none

module leaf_packer (
    input  wire logic          clk,
    input  wire logic          arst_n,
    input  leaf_pkg::payload_t din,
    input  wire logic          vld,
    output logic               ack,
    input  wire logic          full,
    input  leaf_pkg::leaf_t    dest_leaf,
    input  leaf_pkg::port_t    dest_port,
    output logic               push,
    output leaf_pkg::packet_t  packet
);

    import leaf_pkg::*;

    logic    push_q;
    tag_t    tag_q;
    packet_t packet_q;

    assign ack = vld && !full; // Take the word whenever there is room.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            push_q <= 1'b0;
            tag_q  <= '0;
        end else begin
            push_q <= ack;
            if (ack) tag_q <= tag_q + 1'b1; // Wraps at 128.
        end
    end

    always_ff @(posedge clk) begin
        if (ack) begin
            packet_q.valid   <= 1'b1;
            packet_q.leaf    <= dest_leaf;
            packet_q.port    <= dest_port;
            packet_q.tag     <= tag_q;
            packet_q.payload <= din;
        end
    end

    assign push   = push_q;
    assign packet = packet_q;

endmodule

`default_nettype wire

// File: verilog/leaf_interface.sv
`include "leaf_settings.svh"
`default_nettype none

module leaf_interface #(
    parameter leaf_pkg::leaf_t LEAF_ID = 5'd3
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  leaf_pkg::packet_t         din_leaf_bft2interface,
    output leaf_pkg::packet_t         dout_leaf_interface2bft,
    input  wire logic                 resend,
    input  wire logic                 ap_start,
    output logic                      reset_ap_start_user,
    output leaf_pkg::payload_t        dout_leaf_interface2user [`NUM_IN_PORTS],
    output logic [`NUM_IN_PORTS-1:0]  vld_interface2user,
    input  wire logic [`NUM_IN_PORTS-1:0] ack_user2interface,
    input  leaf_pkg::payload_t        din_leaf_user2interface,
    input  wire logic                 vld_user2interface,
    output logic                      ack_interface2user,
    input  leaf_pkg::leaf_t           dest_leaf,
    input  leaf_pkg::port_t           dest_port
);

    import leaf_pkg::*;

    if ($bits(packet_t) != `PACKET_BITS) begin : g_width_chk
        $error("packet_t does not match PACKET_BITS");
    end

    logic [`NUM_IN_PORTS-1:0] port_push;
    logic [`NUM_IN_PORTS-1:0] port_empty;
    payload_t                 port_payload;
    logic                     out_push;
    packet_t                  out_wdata;
    packet_t                  out_rdata;
    logic                     out_empty;
    logic                     out_full;
    logic                     out_pop;
    packet_t                  dout_q;
    logic                     started_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Network to user.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    leaf_unpacker #(.LEAF_ID(LEAF_ID)) u_unpacker (
        .clk     (clk),
        .arst_n  (arst_n),
        .din     (din_leaf_bft2interface),
        .push    (port_push),
        .payload (port_payload)
    );

    for (genvar i = 0; i < `NUM_IN_PORTS; i++) begin : g_port_q
        packet_fifo #(.T(payload_t), .DEPTH(`FIFO_DEPTH)) u_port_fifo (
            .clk    (clk),
            .arst_n (arst_n),
            .push   (port_push[i]),
            .wdata  (port_payload),
            .pop    (ack_user2interface[i]),
            .rdata  (dout_leaf_interface2user[i]),
            .empty  (port_empty[i]),
            .full   ()
        );
    end

    assign vld_interface2user = ~port_empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // User to network.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    leaf_packer u_packer (
        .clk       (clk),
        .arst_n    (arst_n),
        .din       (din_leaf_user2interface),
        .vld       (vld_user2interface),
        .ack       (ack_interface2user),
        .full      (out_full),
        .dest_leaf (dest_leaf),
        .dest_port (dest_port),
        .push      (out_push),
        .packet    (out_wdata)
    );

    packet_fifo #(.T(packet_t), .DEPTH(`FIFO_DEPTH)) u_out_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .push   (out_push),
        .wdata  (out_wdata),
        .pop    (out_pop),
        .rdata  (out_rdata),
        .empty  (out_empty),
        .full   (out_full)
    );

    assign out_pop = !resend && !out_empty;

    // A packet caught by resend is held and shown once resend drops.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout_q <= '0;
        end else if (!resend) begin
            dout_q <= out_empty ? packet_t'('0) : out_rdata;
        end
    end

    assign dout_leaf_interface2bft = resend ? packet_t'('0) : dout_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started_q <= 1'b0;
        end else if (ap_start) begin
            started_q <= 1'b1; // Sticky until arst_n.
        end
    end

    assign reset_ap_start_user = !started_q;

endmodule

`default_nettype wire

// File: verilog/port_sum_kernel.sv
`include "leaf_settings.svh"
`default_nettype none

module port_sum_kernel (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     reset,
    input  leaf_pkg::payload_t            din [`NUM_IN_PORTS],
    input  wire logic [`NUM_IN_PORTS-1:0] vld,
    output logic [`NUM_IN_PORTS-1:0]      ack,
    output leaf_pkg::payload_t            dout,
    output logic                          dout_vld,
    input  wire logic                     dout_ack
);

    import leaf_pkg::*;

    typedef enum logic {
        ST_COLLECT,
        ST_HOLD
    } state_t;

    state_t   state_q;
    logic     ack_q;
    payload_t sum;
    payload_t sum_q;

    always_comb begin
        sum = '0;
        for (int i = 0; i < `NUM_IN_PORTS; i++) begin
            sum = sum + din[i]; // Wraps at 32 bits.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_COLLECT;
            ack_q   <= 1'b0;
        end else if (reset) begin
            state_q <= ST_COLLECT; // Held until ap_start.
            ack_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_COLLECT: begin
                    if (ack_q) begin
                        ack_q   <= 1'b0;
                        state_q <= ST_HOLD;
                    end else if (&vld) begin
                        ack_q <= 1'b1;
                    end
                end
                ST_HOLD: begin
                    if (dout_ack) state_q <= ST_COLLECT;
                end
                default: state_q <= ST_COLLECT;
            endcase
        end
    end

    // Heads are still in place during the ack cycle.
    always_ff @(posedge clk) begin
        if (state_q == ST_COLLECT && ack_q) sum_q <= sum;
    end

    assign ack      = {`NUM_IN_PORTS{ack_q}};
    assign dout     = sum_q;
    assign dout_vld = (state_q == ST_HOLD);

endmodule

`default_nettype wire

// File: verilog/leaf_i7o1.sv
`include "leaf_settings.svh"
`default_nettype none

module leaf_i7o1 #(
    parameter leaf_pkg::leaf_t LEAF_ID = 5'd3
) (
    input  wire logic         clk,
    input  wire logic         arst_n,
    input  leaf_pkg::packet_t din_leaf_bft2interface,
    output leaf_pkg::packet_t dout_leaf_interface2bft,
    input  wire logic         resend,
    input  wire logic         ap_start,
    input  leaf_pkg::leaf_t   dest_leaf,
    input  leaf_pkg::port_t   dest_port
);

    import leaf_pkg::*;

    payload_t                 dout_leaf_interface2user [`NUM_IN_PORTS];
    logic [`NUM_IN_PORTS-1:0] vld_interface2user;
    logic [`NUM_IN_PORTS-1:0] ack_user2interface;
    payload_t                 din_leaf_user2interface;
    logic                     vld_user2interface;
    logic                     ack_interface2user;
    logic                     reset_ap_start_user;

    leaf_interface #(.LEAF_ID(LEAF_ID)) u_interface (
        .clk                      (clk),
        .arst_n                   (arst_n),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .dout_leaf_interface2bft  (dout_leaf_interface2bft),
        .resend                   (resend),
        .ap_start                 (ap_start),
        .reset_ap_start_user      (reset_ap_start_user),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user),
        .dest_leaf                (dest_leaf),
        .dest_port                (dest_port)
    );

    port_sum_kernel u_kernel (
        .clk      (clk),
        .arst_n   (arst_n),
        .reset    (reset_ap_start_user),
        .din      (dout_leaf_interface2user),
        .vld      (vld_interface2user),
        .ack      (ack_user2interface),
        .dout     (din_leaf_user2interface),
        .dout_vld (vld_user2interface),
        .dout_ack (ack_interface2user)
    );

endmodule

`default_nettype wire

// File: tb/leaf_i7o1_chk.sv
`default_nettype none

module leaf_i7o1_chk (
    input  wire logic         clk,
    input  wire logic         arst_n,
    input  wire logic         resend,
    input  leaf_pkg::leaf_t   dest_leaf,
    input  leaf_pkg::packet_t dout_leaf_interface2bft
);

    timeunit 1ns;
    timeprecision 1ps;

    import leaf_pkg::*;

    int fails_resend = 0;
    int fails_reset  = 0;
    int fails_leaf   = 0;
    int assert_fails;

    assign assert_fails = fails_resend + fails_reset + fails_leaf;

    // Network output is blanked for the whole resend window.
    resend_blanks_dout: assert property (
        @(posedge clk) resend |-> (dout_leaf_interface2bft == '0)
    ) else begin
        $error("dout not zero while resend is high");
        fails_resend++;
    end

    reset_blanks_dout: assert property (
        @(posedge clk) !arst_n |-> (dout_leaf_interface2bft == '0)
    ) else begin
        $error("dout not zero while arst_n is low");
        fails_reset++;
    end

    valid_carries_dest: assert property (
        @(posedge clk) disable iff (!arst_n)
        dout_leaf_interface2bft.valid |-> (dout_leaf_interface2bft.leaf == dest_leaf)
    ) else begin
        $error("output packet leaf differs from dest_leaf");
        fails_leaf++;
    end

endmodule

bind leaf_i7o1 leaf_i7o1_chk u_chk (
    .clk                     (clk),
    .arst_n                  (arst_n),
    .resend                  (resend),
    .dest_leaf               (dest_leaf),
    .dout_leaf_interface2bft (dout_leaf_interface2bft)
);

`default_nettype wire

// File: tb/leaf_i7o1_tb.sv
`default_nettype none

module leaf_i7o1_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import leaf_pkg::*;

    localparam string CASE_FILE = "tb/leaf_cases.txt";
    localparam int    SEED      = 25728;

    logic        clk = 1'b0;
    logic        arst_n;
    packet_t     din;
    packet_t     dout;
    logic        resend;
    logic        ap_start;
    leaf_t       dest_leaf;
    port_t       dest_port;

    byte         cmd_q [$];
    logic [31:0] arg_a [$];
    logic [31:0] arg_b [$];
    logic [31:0] arg_c [$];
    payload_t    exp_q [$];
    tag_t        exp_tag = '0;
    int          cycle_limit = 0;
    int          cycles = 0;
    int          checked = 0;
    int          mismatch_errs = 0;
    int          other_errs = 0;

    leaf_i7o1 #(.LEAF_ID(5'd3)) UUT (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .resend                  (resend),
        .ap_start                (ap_start),
        .dest_leaf               (dest_leaf),
        .dest_port               (dest_port)
    );

    always #10 clk = ~clk; // 20 ns period.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic compare_payload(string name, payload_t got, payload_t exp);
        checked++;
        if (got !== exp) begin
            mismatch_errs++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_tag(string name, tag_t got, tag_t exp);
        checked++;
        if (got !== exp) begin
            mismatch_errs++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_addr(leaf_t got_leaf, port_t got_port, leaf_t exp_leaf,
                                port_t exp_port);
        checked++;
        if (got_leaf !== exp_leaf) begin
            mismatch_errs++;
            $display("Mismatch at %0t: dout.leaf got %h, expected %h",
                     $time, got_leaf, exp_leaf);
        end
        if (got_port !== exp_port) begin
            mismatch_errs++;
            $display("Mismatch at %0t: dout.port got %h, expected %h",
                     $time, got_port, exp_port);
        end
    endtask

    task automatic check_output();
        payload_t exp;
        if (exp_q.size() == 0) begin
            other_errs++;
            $display("Error at %0t: output packet %h arrived with no result expected",
                     $time, dout);
        end else begin
            exp = exp_q.pop_front();
            compare_payload("dout.payload", dout.payload, exp);
            compare_tag("dout.tag", dout.tag, exp_tag);
            compare_addr(dout.leaf, dout.port, dest_leaf, dest_port);
            exp_tag++; // Wraps with the DUT's 7-bit tag.
        end
    endtask

    // Sampled mid-cycle, away from both edges.
    always @(negedge clk) begin
        if (arst_n && dout.valid) check_output();
    end

    task automatic finish_run();
        int total;
        if (exp_q.size() != 0) begin
            other_errs += exp_q.size();
            $display("Error: %0d expected results never appeared", exp_q.size());
        end
        total = mismatch_errs + other_errs + UUT.u_chk.assert_fails;
        $display("Checks: %0d, mismatches: %0d, other errors: %0d, assertion failures: %0d",
                 checked, mismatch_errs, other_errs, UUT.u_chk.assert_fails);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic load_cases(output bit ok);
        int               fd;
        bit               done;
        logic [63:0]      tok;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [8*256-1:0] rest;
        ok = 1'b0;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Error: cannot open case file %s", CASE_FILE);
        end else begin
            ok = 1'b1;
            done = 1'b0;
            while (!done) begin
                a = '0;
                b = '0;
                c = '0;
                if ($fscanf(fd, "%s", tok) != 1) begin
                    done = 1'b1;
                end else if (tok == "#") begin
                    void'($fgets(rest, fd)); // Comment line.
                end else begin
                    case (tok)
                        "P":      ok = ($fscanf(fd, "%d %d %h", a, b, c) == 3);
                        "R", "W": ok = ($fscanf(fd, "%d", a) == 1);
                        "E":      ok = ($fscanf(fd, "%h", a) == 1);
                        "S":      ok = 1'b1;
                        default:  ok = 1'b0;
                    endcase
                    if (ok) begin
                        cmd_q.push_back(tok[7:0]);
                        arg_a.push_back(a);
                        arg_b.push_back(b);
                        arg_c.push_back(c);
                    end else begin
                        $display("Error: bad command %0s in case file", tok);
                        done = 1'b1;
                    end
                end
            end
            $fclose(fd);
            cycle_limit = 40 * cmd_q.size() + 200;
        end
    endtask

    task automatic run_cases();
        int unsigned gap;
        packet_t     pkt;
        for (int i = 0; i < cmd_q.size(); i++) begin
            case (cmd_q[i])
                "P": begin
                    pkt.valid   = 1'b1;
                    pkt.leaf    = leaf_t'(arg_a[i]);
                    pkt.port    = port_t'(arg_b[i]);
                    pkt.tag     = 7'h55; // Ignored by the leaf.
                    pkt.payload = arg_c[i];
                    din = pkt;
                    tick();
                    din = '0;
                    gap = $urandom % 3;
                    repeat (gap) tick();
                end
                "S": begin
                    ap_start = 1'b1;
                    tick();
                    ap_start = 1'b0;
                end
                "R": begin
                    resend = 1'b1;
                    repeat (arg_a[i]) tick();
                    resend = 1'b0;
                end
                "W": repeat (arg_a[i]) tick();
                "E": exp_q.push_back(arg_a[i]);
                default: ;
            endcase
        end
    endtask

    initial begin : watchdog
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        other_errs++;
        $display("Error: run timed out after %0d cycles", cycles);
        finish_run();
    end

    initial begin : main
        bit loaded;
        int seed;
        din       = '0;
        resend    = 1'b0;
        ap_start  = 1'b0;
        dest_leaf = 5'd9;
        dest_port = 4'd2;
        arst_n    = 1'b1;
        seed      = SEED;
        void'($urandom(seed));
        load_cases(loaded);
        #1 arst_n = 1'b0;
        repeat (10) @(posedge clk);
        #2 arst_n = 1'b1;
        if (!loaded) begin
            other_errs++;
            finish_run();
        end else begin
            tick();
            run_cases();
            while (exp_q.size() != 0) @(posedge clk);
            repeat (20) @(posedge clk); // Catch any stray packet.
            finish_run();
        end
    end

endmodule

`default_nettype wire

// File: tb/leaf_cases.txt
# P leaf port data(hex) | S | R cycles | W cycles | E sum(hex)
# This leaf is 3. Results go to leaf 9 port 2, tags count up from 0.
P 3 1 00000001
P 3 2 00000002
P 3 3 00000004
P 3 4 00000008
P 3 5 00000010
P 3 6 00000020
P 3 7 00000040
W 10
S
E 0000007f
P 4 1 deadbeef
P 3 0 0badf00d
P 3 12 12345678
P 3 1 11111111
P 3 2 22222222
P 3 3 33333333
P 3 4 44444444
P 3 5 55555555
P 3 6 66666666
P 3 7 77777777
E dddddddc
P 3 1 00000100
P 3 1 00000200
P 3 2 00001000
P 3 3 00002000
P 3 4 00003000
P 3 5 00004000
P 3 6 00005000
P 3 7 00006000
E 00015100
P 3 2 00010000
P 3 3 00010000
P 3 4 00010000
P 3 5 00010000
P 3 6 00010000
P 3 7 00010000
E 00060200
P 3 1 ffffffff
P 3 2 ffffffff
P 3 3 ffffffff
P 3 4 ffffffff
P 3 5 ffffffff
P 3 6 ffffffff
P 3 7 ffffffff
R 30
E fffffff9

// File: leaf_i7o1.f
+incdir+verilog
verilog/leaf_pkg.sv
verilog/packet_fifo.sv
verilog/leaf_unpacker.sv
verilog/leaf_packer.sv
verilog/leaf_interface.sv
verilog/port_sum_kernel.sv
verilog/leaf_i7o1.sv
tb/leaf_i7o1_chk.sv
tb/leaf_i7o1_tb.sv

// File: Bender.yml
package:
  name: leaf_i7o1

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/leaf_pkg.sv
      - verilog/packet_fifo.sv
      - verilog/leaf_unpacker.sv
      - verilog/leaf_packer.sv
      - verilog/leaf_interface.sv
      - verilog/port_sum_kernel.sv
      - verilog/leaf_i7o1.sv
  - target: test
    files:
      - tb/leaf_i7o1_chk.sv
      - tb/leaf_i7o1_tb.sv
